//--- codec_config.svh
`ifndef CODEC_CONFIG_SVH
`define CODEC_CONFIG_SVH

// 7-bit slave address of the codec, r/w bit appended as 0
`define CFG_DEV_ADDR 7'h1a

// clk_200k ticks per bus bit
`define CFG_TICKS_PER_BIT 12

// entries in the init table
`define CFG_NUM_WRITES 6

`endif

//--- i2c_bus_pkg.sv
package i2c_bus_pkg;

  // frame states, one per bus slot group
  typedef enum logic [3:0] {
    idle,
    start,
    addr,      // device address byte
    ack_addr,
    cmd,       // command byte
    ack_cmd,
    data,      // data byte
    ack_data,
    stop
  } frame_state_t;

  // which byte of the frame is on the wire
  typedef enum logic [1:0] {
    slot_addr,
    slot_cmd,
    slot_data
  } byte_slot_t;

endpackage

//--- codec_cfg_pkg.sv
`include "codec_config.svh"

package codec_cfg_pkg;

  typedef logic [$clog2(`CFG_NUM_WRITES)-1:0] table_idx_t;

  // codec register layout
  typedef struct packed {
    logic [6:0] reg_addr;
    logic [8:0] reg_value;
  } codec_fields_t;

  // as sent on the bus
  typedef struct packed {
    logic [7:0] cmd_byte;
    logic [7:0] data_byte;
  } codec_bytes_t;

  typedef union packed {
    codec_bytes_t  bytes;
    codec_fields_t fields;
  } codec_reg_word_u;

  // power-up sequence, written in order
  localparam codec_fields_t init_table [0:`CFG_NUM_WRITES-1] = '{
    '{7'h0f, 9'h000},  // reset
    '{7'h06, 9'h000},  // power up all blocks
    '{7'h04, 9'h012},  // dac select, bypass off
    '{7'h05, 9'h000},  // no de-emphasis, unmute
    '{7'h07, 9'h042},  // master, i2s 16 bit
    '{7'h09, 9'h001}   // activate
  };

endpackage

//--- write_req_if.sv
`timescale 1ns/1ns

interface write_req_if;

  logic                         req;     // one cycle, engine idle
  codec_cfg_pkg::codec_reg_word_u word;  // held by sequencer
  logic                         done;    // one cycle, end of stop slot
  logic                         ack_ok;  // valid with done

  modport seq_mp (
    output req,
    output word,
    input  done,
    input  ack_ok
  );

  modport eng_mp (
    input  req,
    input  word,
    output done,
    output ack_ok
  );

endinterface

//--- bit_phase_timer.sv
`timescale 1ns/1ns
`include "codec_config.svh"

module bit_phase_timer (
  input  logic clk_200k,
  input  logic rst_n,
  input  logic run,
  output logic scl_rise,
  output logic scl_fall,
  output logic slot_end
);

  // phase boundaries as quarters of a bit
  localparam int tick_rise = `CFG_TICKS_PER_BIT / 4;
  localparam int tick_fall = (3 * `CFG_TICKS_PER_BIT) / 4;
  localparam int tick_last = `CFG_TICKS_PER_BIT - 1;

  logic [3:0] tick;

  always_ff @(posedge clk_200k or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tick     <= 4'd0;
      scl_rise <= 1'b0;
      scl_fall <= 1'b0;
      slot_end <= 1'b0;
    end
    else
    begin
      if (!run)
        tick <= 4'd0;
      else if (tick == 4'(tick_last))
        tick <= 4'd0;  // wrap into next slot
      else
        tick <= tick + 4'd1;

      scl_rise <= run && (tick == 4'(tick_rise));
      scl_fall <= run && (tick == 4'(tick_fall));
      slot_end <= run && (tick == 4'(tick_last));
    end
  end

endmodule

//--- codec_write_seq.sv
`timescale 1ns/1ns
`include "codec_config.svh"

module codec_write_seq (
  input  logic                      clk_200k,
  input  logic                      rst_n,
  input  logic                      go,
  output logic                      busy,
  output logic                      all_done,
  output logic                      nack_err,
  output codec_cfg_pkg::table_idx_t write_index,
  write_req_if.seq_mp               wr
);

  logic req_q;
  logic last_entry;

  assign last_entry = (write_index == codec_cfg_pkg::table_idx_t'(`CFG_NUM_WRITES - 1));

  // word follows the index, engine latches it on req
  assign wr.word.fields = codec_cfg_pkg::init_table[write_index];
  assign wr.req = req_q;

  always_ff @(posedge clk_200k or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy        <= 1'b0;
      all_done    <= 1'b0;
      nack_err    <= 1'b0;
      write_index <= '0;
      req_q       <= 1'b0;
    end
    else
    begin
      req_q    <= 1'b0;
      all_done <= 1'b0;

      if (!busy)
      begin
        if (go)
        begin
          busy        <= 1'b1;
          write_index <= '0;
          nack_err    <= 1'b0;  // cleared by a new run
          req_q       <= 1'b1;
        end
      end
      else if (wr.done)
      begin
        if (!wr.ack_ok)
        begin
          // abort, index stays on the failing entry
          busy     <= 1'b0;
          all_done <= 1'b1;
          nack_err <= 1'b1;
        end
        else if (last_entry)
        begin
          busy     <= 1'b0;
          all_done <= 1'b1;
        end
        else
        begin
          write_index <= write_index + 1'b1;
          req_q       <= 1'b1;
        end
      end
    end
  end

endmodule

//--- i2c_write_engine.sv
`timescale 1ns/1ns
`include "codec_config.svh"

module i2c_write_engine (
  input  logic        clk_200k,
  input  logic        rst_n,
  input  logic        scl_rise,
  input  logic        scl_fall,
  input  logic        slot_end,
  output logic        run,
  output logic        scl,
  output logic        sda_out,
  output logic        sda_oe,
  input  logic        sda_in,
  write_req_if.eng_mp wr
);

  i2c_bus_pkg::frame_state_t      state;
  i2c_bus_pkg::frame_state_t      seq_next;
  i2c_bus_pkg::byte_slot_t        cur_slot;
  codec_cfg_pkg::codec_reg_word_u word_q;
  logic [2:0]                     bit_idx;
  logic [7:0]                     cur_byte;
  logic                           ack_bad;

  assign run = (state != i2c_bus_pkg::idle);

  assign wr.done   = slot_end && (state == i2c_bus_pkg::stop);
  assign wr.ack_ok = ~ack_bad;

  // regular order through the frame
  always_comb
  begin
    case (state)
      i2c_bus_pkg::start:    seq_next = i2c_bus_pkg::addr;
      i2c_bus_pkg::addr:     seq_next = i2c_bus_pkg::ack_addr;
      i2c_bus_pkg::ack_addr: seq_next = i2c_bus_pkg::cmd;
      i2c_bus_pkg::cmd:      seq_next = i2c_bus_pkg::ack_cmd;
      i2c_bus_pkg::ack_cmd:  seq_next = i2c_bus_pkg::data;
      i2c_bus_pkg::data:     seq_next = i2c_bus_pkg::ack_data;
      i2c_bus_pkg::ack_data: seq_next = i2c_bus_pkg::stop;
      default:               seq_next = i2c_bus_pkg::idle;
    endcase
  end

  always_comb
  begin
    case (state)
      i2c_bus_pkg::addr, i2c_bus_pkg::ack_addr: cur_slot = i2c_bus_pkg::slot_addr;
      i2c_bus_pkg::cmd, i2c_bus_pkg::ack_cmd:   cur_slot = i2c_bus_pkg::slot_cmd;
      default:                                  cur_slot = i2c_bus_pkg::slot_data;
    endcase
  end

  always_comb
  begin
    case (cur_slot)
      i2c_bus_pkg::slot_addr: cur_byte = {`CFG_DEV_ADDR, 1'b0};  // write
      i2c_bus_pkg::slot_cmd:  cur_byte = word_q.bytes.cmd_byte;
      default:                cur_byte = word_q.bytes.data_byte;
    endcase
  end

  always_ff @(posedge clk_200k)
  begin
    if (wr.req && (state == i2c_bus_pkg::idle))
      word_q <= wr.word;
  end

  // frame sequencing, one step per slot_end
  always_ff @(posedge clk_200k or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state   <= i2c_bus_pkg::idle;
      bit_idx <= 3'd7;
      ack_bad <= 1'b0;
    end
    else
    begin
      case (state)
        i2c_bus_pkg::idle:
        begin
          if (wr.req)
          begin
            state   <= i2c_bus_pkg::start;
            bit_idx <= 3'd7;
            ack_bad <= 1'b0;
          end
        end
        i2c_bus_pkg::addr, i2c_bus_pkg::cmd, i2c_bus_pkg::data:
        begin
          if (slot_end)
          begin
            bit_idx <= bit_idx - 3'd1;  // wraps to 7 after bit 0
            if (bit_idx == 3'd0)
              state <= seq_next;
          end
        end
        i2c_bus_pkg::ack_addr, i2c_bus_pkg::ack_cmd, i2c_bus_pkg::ack_data:
        begin
          if (scl_fall)
            ack_bad <= sda_in;  // single sample per ack slot
          if (slot_end)
            state <= ack_bad ? i2c_bus_pkg::stop : seq_next;
        end
        default:
        begin
          if (slot_end)
            state <= seq_next;
        end
      endcase
    end
  end

  // pin drive, registered behind the phase strobes
  always_ff @(posedge clk_200k or negedge rst_n)
  begin
    if (!rst_n)
    begin
      scl     <= 1'b1;
      sda_out <= 1'b1;
      sda_oe  <= 1'b1;
    end
    else
    begin
      case (state)
        i2c_bus_pkg::start:
        begin
          if (scl_rise)
            sda_out <= 1'b0;  // start, sda falls with scl high
          if (scl_fall)
            scl <= 1'b0;
        end
        i2c_bus_pkg::addr, i2c_bus_pkg::cmd, i2c_bus_pkg::data:
        begin
          sda_oe  <= 1'b1;
          sda_out <= cur_byte[bit_idx];  // msb first
          if (scl_rise)
            scl <= 1'b1;
          if (scl_fall)
            scl <= 1'b0;
        end
        i2c_bus_pkg::ack_addr, i2c_bus_pkg::ack_cmd, i2c_bus_pkg::ack_data:
        begin
          sda_oe  <= 1'b0;  // slave owns sda
          sda_out <= 1'b0;  // low ready for stop
          if (scl_rise)
            scl <= 1'b1;
          if (scl_fall)
            scl <= 1'b0;
        end
        i2c_bus_pkg::stop:
        begin
          sda_oe <= 1'b1;
          if (scl_rise)
            scl <= 1'b1;
          if (scl_fall)
            sda_out <= 1'b1;  // stop, sda rises with scl high
        end
        default:
        begin
          scl     <= 1'b1;
          sda_out <= 1'b1;
          sda_oe  <= 1'b1;
        end
      endcase
    end
  end

endmodule

//--- codec_i2c_cfg_top.sv
`timescale 1ns/1ns

module codec_i2c_cfg_top (
  input  logic                      clk_200k,
  input  logic                      rst_n,
  input  logic                      go,
  output logic                      scl,
  output logic                      sda_out,
  output logic                      sda_oe,
  input  logic                      sda_in,
  output logic                      busy,
  output logic                      all_done,
  output logic                      nack_err,
  output codec_cfg_pkg::table_idx_t write_index
);

  logic run;
  logic scl_rise;
  logic scl_fall;
  logic slot_end;

  write_req_if wr_if ();

  bit_phase_timer i_bit_phase_timer (
    .clk_200k (clk_200k),
    .rst_n    (rst_n),
    .run      (run),
    .scl_rise (scl_rise),
    .scl_fall (scl_fall),
    .slot_end (slot_end)
  );

  codec_write_seq i_codec_write_seq (
    .clk_200k    (clk_200k),
    .rst_n       (rst_n),
    .go          (go),
    .busy        (busy),
    .all_done    (all_done),
    .nack_err    (nack_err),
    .write_index (write_index),
    .wr          (wr_if.seq_mp)
  );

  i2c_write_engine i_i2c_write_engine (
    .clk_200k (clk_200k),
    .rst_n    (rst_n),
    .scl_rise (scl_rise),
    .scl_fall (scl_fall),
    .slot_end (slot_end),
    .run      (run),
    .scl      (scl),
    .sda_out  (sda_out),
    .sda_oe   (sda_oe),
    .sda_in   (sda_in),
    .wr       (wr_if.eng_mp)
  );

endmodule

//--- tb_codec_i2c_cfg.sv
`timescale 1ns/1ns
`include "codec_config.svh"

module tb_codec_i2c_cfg;

  localparam int tpb        = `CFG_TICKS_PER_BIT;
  localparam int max_frames = 16;
  localparam int wait_limit = 40000;

  logic                      clk_200k;
  logic                      rst_n;
  logic                      go;
  logic                      scl;
  logic                      sda_out;
  logic                      sda_oe;
  logic                      sda_in;
  logic                      busy;
  logic                      all_done;
  logic                      nack_err;
  codec_cfg_pkg::table_idx_t write_index;

  logic       slave_sda;  // slave pull-down, 1 = released
  logic       bus_sda;
  integer     seed;
  int         cyc;
  int         frame_count;
  int         run_byte;   // byte number within one table run
  int         nack_at;
  logic       prev_scl;
  logic       prev_sda;
  logic       in_frame;
  logic       rise_seen;
  int         hi_cnt;
  int         bit_cnt;
  int         byte_cnt;
  int         start_cyc;
  logic [7:0] shreg;
  logic [7:0] cap_bytes [0:max_frames-1][0:2];
  int         cap_nbytes [0:max_frames-1];
  int         cap_span [0:max_frames-1];

  // open-drain wiring of sda
  assign bus_sda = (sda_oe ? sda_out : 1'b1) & slave_sda;
  assign sda_in  = bus_sda;

  codec_i2c_cfg_top i_codec_i2c_cfg_top (
    .clk_200k    (clk_200k),
    .rst_n       (rst_n),
    .go          (go),
    .scl         (scl),
    .sda_out     (sda_out),
    .sda_oe      (sda_oe),
    .sda_in      (sda_in),
    .busy        (busy),
    .all_done    (all_done),
    .nack_err    (nack_err),
    .write_index (write_index)
  );

  initial
  begin
    clk_200k = 1'b0;
    forever #50 clk_200k = ~clk_200k;
  end

  task automatic fail_now(input string msg);
    begin
      $display("%s", msg);
      $display("TESTBENCH FAILED");
      $fatal(1, "stopped on first error");
    end
  endtask

  task automatic check_word(input string name, input codec_cfg_pkg::codec_reg_word_u exp_w,
                            input codec_cfg_pkg::codec_reg_word_u act_w);
    begin
      if (act_w !== exp_w)
        fail_now($sformatf("Fail at %0t ns: %s expected %h (reg %h val %h) got %h (reg %h val %h)",
                           $time, name, exp_w, exp_w.fields.reg_addr, exp_w.fields.reg_value,
                           act_w, act_w.fields.reg_addr, act_w.fields.reg_value));
    end
  endtask

  task automatic check_flag(input string name, input logic exp_v, input logic act_v);
    begin
      if (act_v !== exp_v)
        fail_now($sformatf("Fail at %0t ns: %s expected %b got %b", $time, name, exp_v, act_v));
    end
  endtask

  task automatic check_index(input string name, input codec_cfg_pkg::table_idx_t exp_v,
                             input codec_cfg_pkg::table_idx_t act_v);
    begin
      if (act_v !== exp_v)
        fail_now($sformatf("Fail at %0t ns: %s expected %0d got %0d", $time, name, exp_v, act_v));
    end
  endtask

  task automatic check_value(input string name, input int exp_v, input int act_v);
    begin
      if (act_v != exp_v)
        fail_now($sformatf("Fail at %0t ns: %s expected %0d got %0d", $time, name, exp_v, act_v));
    end
  endtask

  // slave model, samples the bus once per cycle
  always @(posedge clk_200k)
  begin
    #10;
    cyc = cyc + 1;
    if (!rst_n)
    begin
      in_frame  = 1'b0;
      slave_sda = 1'b1;
    end
    else if (prev_scl && scl && prev_sda && !bus_sda)
    begin
      in_frame  = 1'b1;  // start
      rise_seen = 1'b0;
      start_cyc = cyc;
      bit_cnt   = 0;
      byte_cnt  = 0;
    end
    else if (prev_scl && scl && !prev_sda && bus_sda && in_frame)
    begin
      in_frame = 1'b0;  // stop
      if (frame_count < max_frames)
      begin
        cap_nbytes[frame_count] = byte_cnt;
        cap_span[frame_count]   = cyc - start_cyc;
      end
      frame_count = frame_count + 1;
    end
    else if (!prev_scl && scl && in_frame)
    begin
      rise_seen = 1'b1;
      hi_cnt    = 0;
      if (bit_cnt < 8)
      begin
        shreg   = {shreg[6:0], bus_sda};
        bit_cnt = bit_cnt + 1;
      end
    end
    else if (prev_scl && !scl && in_frame)
    begin
      if (rise_seen)
        check_value("scl high cycles", tpb / 2, hi_cnt);
      if (bit_cnt == 8)
      begin
        if (frame_count < max_frames && byte_cnt < 3)
          cap_bytes[frame_count][byte_cnt] = shreg;
        slave_sda = (run_byte == nack_at) ? 1'b1 : 1'b0;  // ack unless injected nack
        run_byte  = run_byte + 1;
        bit_cnt   = 9;
      end
      else if (bit_cnt == 9)
      begin
        slave_sda = 1'b1;
        bit_cnt   = 0;
        byte_cnt  = byte_cnt + 1;
      end
    end
    if (scl)
      hi_cnt = hi_cnt + 1;
    prev_scl = scl;
    prev_sda = bus_sda;
  end

  task automatic wait_all_done(input int limit);
    int n;
    begin
      n = 0;
      while (all_done !== 1'b1)
      begin
        if (n >= limit)
          fail_now("timeout: all_done never came after go");
        else
        begin
          @(posedge clk_200k);
          #10;
          n = n + 1;
        end
      end
    end
  endtask

  task automatic pulse_go();
    begin
      go = 1'b1;
      @(posedge clk_200k);
      #10;
      go = 1'b0;
    end
  endtask

  task automatic run_table(input int exp_count, input int nack_byte, input logic [15:0] w [0:5]);
    int   gap;
    int   f;
    int   nb;
    int   exp_span;
    codec_cfg_pkg::table_idx_t      exp_idx;
    codec_cfg_pkg::codec_reg_word_u exp_w;
    codec_cfg_pkg::codec_reg_word_u got_w;
    begin
      gap = 10 + ($unsigned($random(seed)) % 40);
      repeat (gap) @(posedge clk_200k);
      #10;
      frame_count = 0;
      run_byte    = 0;
      nack_at     = nack_byte;
      pulse_go();
      check_flag("busy", 1'b1, busy);
      check_flag("nack_err", 1'b0, nack_err);
      repeat (50) @(posedge clk_200k);
      #10;
      check_flag("busy", 1'b1, busy);
      pulse_go();  // dropped while busy
      wait_all_done(wait_limit);
      check_flag("busy", 1'b0, busy);
      exp_idx = (nack_byte >= 0) ? codec_cfg_pkg::table_idx_t'(nack_byte / 3)
                                 : codec_cfg_pkg::table_idx_t'(`CFG_NUM_WRITES - 1);
      check_flag("nack_err", (nack_byte >= 0), nack_err);
      check_index("write_index", exp_idx, write_index);
      check_value("frame count", exp_count, frame_count);
      @(posedge clk_200k);
      #10;
      check_flag("all_done", 1'b0, all_done);  // single cycle pulse
      for (f = 0; f < exp_count; f++)
      begin
        nb = (nack_byte >= 0 && f == exp_count - 1) ? (nack_byte % 3) + 1 : 3;
        // start to stop edge: all slots but the last, plus half a bit
        exp_span = (9 * nb + 1) * tpb + tpb / 2;
        exp_w    = w[f];
        check_value("bytes in frame", nb, cap_nbytes[f]);
        check_value("frame span cycles", exp_span, cap_span[f]);
        check_value("address byte", {`CFG_DEV_ADDR, 1'b0}, cap_bytes[f][0]);
        if (nb == 3)
        begin
          got_w.bytes.cmd_byte  = cap_bytes[f][1];
          got_w.bytes.data_byte = cap_bytes[f][2];
          check_word("register word", exp_w, got_w);
        end
        else if (nb == 2)
          check_value("cmd byte", exp_w.bytes.cmd_byte, cap_bytes[f][1]);
      end
      repeat (2 * 29 * tpb) @(posedge clk_200k);
      #10;
      check_value("frame count after end", exp_count, frame_count);
      check_flag("busy", 1'b0, busy);
    end
  endtask

  initial
  begin
    int          fd;
    int          code;
    int          n;
    int          runs;
    int          exp_count;
    int          nack_byte;
    string       line;
    logic [15:0] w [0:5];
    seed        = 32'hfe1e;
    cyc         = 0;
    frame_count = 0;
    run_byte    = 0;
    nack_at     = -1;
    slave_sda   = 1'b1;
    prev_scl    = 1'b1;
    prev_sda    = 1'b1;
    in_frame    = 1'b0;
    rise_seen   = 1'b0;
    hi_cnt      = 0;
    bit_cnt     = 0;
    byte_cnt    = 0;
    start_cyc   = 0;
    shreg       = 8'h00;
    runs        = 0;
    go          = 1'b0;
    rst_n       = 1'b0;
    repeat (5) @(posedge clk_200k);
    #10;
    rst_n = 1'b1;
    @(posedge clk_200k);
    #10;
    check_flag("scl", 1'b1, scl);
    check_flag("sda_out", 1'b1, sda_out);
    check_flag("sda_oe", 1'b1, sda_oe);
    check_flag("busy", 1'b0, busy);
    check_flag("all_done", 1'b0, all_done);
    check_flag("nack_err", 1'b0, nack_err);

    fd = $fopen("codec_stim.txt", "r");
    if (fd == 0)
      fail_now("could not open codec_stim.txt");
    while (!$feof(fd))
    begin
      code = $fgets(line, fd);
      if (code != 0 && line.len() > 0 && line[0] != 8'h23)
      begin
        n = $sscanf(line, "%d %d %h %h %h %h %h %h", exp_count, nack_byte,
                    w[0], w[1], w[2], w[3], w[4], w[5]);
        if (n >= 2)
        begin
          if (n != exp_count + 2)
            fail_now("stimulus line has the wrong number of words");
          run_table(exp_count, nack_byte, w);
          runs = runs + 1;
        end
      end
    end
    $fclose(fd);
    if (runs == 0)
      fail_now("stimulus file held no runs");

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

//--- codec_stim.txt
# columns: frames expected, byte to nack within the run (-1 none), then one hex word per frame
# word is reg_addr[15:9] and reg_value[8:0]
6 -1 1e00 0c00 0812 0a00 0e42 1201
3 7 1e00 0c00 0812
6 -1 1e00 0c00 0812 0a00 0e42 1201
1 0 1e00
6 17 1e00 0c00 0812 0a00 0e42 1201
2 5 1e00 0c00
4 9 1e00 0c00 0812 0a00
6 -1 1e00 0c00 0812 0a00 0e42 1201

//--- flist.f
+incdir+.
i2c_bus_pkg.sv
codec_cfg_pkg.sv
write_req_if.sv
bit_phase_timer.sv
codec_write_seq.sv
i2c_write_engine.sv
codec_i2c_cfg_top.sv
tb_codec_i2c_cfg.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_codec_i2c_cfg
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(shell grep -v '^+' $(FLIST)) codec_config.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
